// File: conv_defines.svh
// Convolution engine sizing
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_WORD_IN      8    // Signed pixel and weight
`define CONV_WORD_OUT     24   // Signed accumulated sum

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Parallelism
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_CORES        2    // Output channels per beat
`define CONV_UNITS        2    // Pixel lanes per beat
`define CONV_KW           3    // Kernel width and tap count

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing and counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_MUL_LATENCY  2    // Multiplier register stages
`define CONV_COL_BITS     8    // Column counter width

`endif

// File: conv_pkg.sv
// Convolution engine types
`default_nettype none
`include "conv_defines.svh"

package conv_pkg;

  typedef logic signed [`CONV_WORD_IN-1:0]   word_in_t;    // Pixel or weight
  typedef logic signed [2*`CONV_WORD_IN-1:0] word_prod_t;  // Full precision product
  typedef logic signed [`CONV_WORD_OUT-1:0]  word_out_t;   // Accumulator word

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream beats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    word_in_t [`CONV_UNITS-1:0]               pixels;    // One channel per unit
    word_in_t [`CONV_CORES-1:0][`CONV_KW-1:0] weights;   // Taps of this channel
    logic                                     cin_last;  // Last channel of column
    logic                                     last;      // Last column of row
  } conv_in_t;

  typedef struct packed {
    word_out_t [`CONV_CORES-1:0][`CONV_UNITS-1:0] data;  // Finished sums
    logic                                         last;  // Final output of row
  } conv_out_t;

  // Products for every core, unit and tap
  typedef word_prod_t [`CONV_CORES-1:0][`CONV_UNITS-1:0][`CONV_KW-1:0] prod_t;

  // Flags riding beside the products
  typedef struct packed {
    logic cin_last;  // Closes a column
    logic last;      // Closes a row
    logic emit;      // Column index at least KW-1
  } beat_tag_t;

  typedef enum logic {
    FILL,            // Warm-up columns of a row
    RUN              // Full kernel window available
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: mul_pipe.sv
// Pipelined multiplier array
`timescale 1ns/1ps
`default_nettype none
`include "conv_defines.svh"

module mul_pipe (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,          // Pipeline advance
  input  logic               in_valid,    // Beat present on input
  input  conv_pkg::conv_in_t in_beat,
  output conv_pkg::prod_t    prod,        // Aligned with tag pipe
  output logic               prod_valid
);

  conv_pkg::prod_t              prod_d;                      // Products of current beat
  conv_pkg::prod_t              prod_q [`CONV_MUL_LATENCY];  // Product stages
  logic [`CONV_MUL_LATENCY-1:0] valid_q;                     // Valid stages

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Every unit pixel times every core weight per tap
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int c = 0; c < `CONV_CORES; c++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        for (int w = 0; w < `CONV_KW; w++) begin
          if (in_valid) begin
            prod_d[c][u][w] = $signed(in_beat.pixels[u]) * $signed(in_beat.weights[c][w]);
          end else begin
            prod_d[c][u][w] = '0;  // Bubble adds nothing downstream
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      prod_q[0] <= prod_d;                          // First stage
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        prod_q[i] <= prod_q[i-1];                   // Shift on advance only
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (en) begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign prod       = prod_q[`CONV_MUL_LATENCY-1];   // Last stage out
  assign prod_valid = valid_q[`CONV_MUL_LATENCY-1];

endmodule

`default_nettype wire

// File: conv_control.sv
// Column counting and tag pipe
`timescale 1ns/1ps
`default_nettype none
`include "conv_defines.svh"

module conv_control (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,         // Pipeline advance
  input  logic                in_valid,
  input  logic                cin_last,   // Column closes on this beat
  input  logic                last,       // Row closes on this beat
  output conv_pkg::beat_tag_t tag,        // Delayed to meet the products
  output logic                tag_valid
);

  logic                        take;      // Input beat accepted
  logic [`CONV_COL_BITS-1:0]   col_q;     // Column index within row
  conv_pkg::ctrl_state_e       state_q;
  conv_pkg::beat_tag_t         tag_d;     // Stamp for the incoming beat
  conv_pkg::beat_tag_t         tag_q [`CONV_MUL_LATENCY];
  logic [`CONV_MUL_LATENCY-1:0] valid_q;

  assign take = in_valid && en;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row position
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q   <= '0;
      state_q <= conv_pkg::FILL;
    end else if (take) begin
      if (last) begin
        col_q   <= '0;                    // Next row starts over
        state_q <= conv_pkg::FILL;
      end else if (cin_last) begin
        col_q <= col_q + 1'b1;
        if (col_q == `CONV_COL_BITS'(`CONV_KW-2)) begin
          state_q <= conv_pkg::RUN;       // Window now spans KW columns
        end
      end
    end
  end

  always_comb begin
    tag_d.cin_last = cin_last;
    tag_d.last     = last;
    tag_d.emit     = (state_q == conv_pkg::RUN);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Delay matching the multiplier
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (en) begin
      tag_q[0] <= tag_d;
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (en) begin
      valid_q[0] <= in_valid;             // Accepted whenever en is high
      for (int i = 1; i < `CONV_MUL_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  assign tag       = tag_q[`CONV_MUL_LATENCY-1];
  assign tag_valid = valid_q[`CONV_MUL_LATENCY-1];

endmodule

`default_nettype wire

// File: tap_chain.sv
// Kernel tap accumulators and column carry chain
`timescale 1ns/1ps
`default_nettype none
`include "conv_defines.svh"

module tap_chain (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,         // Pipeline advance
  input  conv_pkg::prod_t     prod,
  input  conv_pkg::beat_tag_t tag,
  input  logic                tag_valid,
  output conv_pkg::conv_out_t out_beat,   // Candidate for output register
  output logic                out_valid
);

  logic take;                             // Product beat consumed this cycle
  logic col_first_q;                      // Next beat opens a column
  logic out_last_q;                       // Row end of pending output

  conv_pkg::word_out_t acc_q   [`CONV_CORES][`CONV_UNITS][`CONV_KW];    // Running sums
  conv_pkg::word_out_t carry_q [`CONV_CORES][`CONV_UNITS][`CONV_KW-1];  // Closed column sums
  conv_pkg::word_out_t sum_d   [`CONV_CORES][`CONV_UNITS][`CONV_KW];    // Next sums

  assign take = en && tag_valid;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Adders with column start select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar c = 0; c < `CONV_CORES; c++) begin : g_core
    for (genvar u = 0; u < `CONV_UNITS; u++) begin : g_unit
      for (genvar w = 0; w < `CONV_KW; w++) begin : g_tap
        conv_pkg::word_out_t base;        // Addend picked ahead of product
        if (w == 0) begin : g_head
          assign base = col_first_q ? '0 : acc_q[c][u][w];                 // Fresh window
        end else begin : g_link
          assign base = col_first_q ? carry_q[c][u][w-1] : acc_q[c][u][w]; // Pull lower tap
        end
        assign sum_d[c][u][w] = base + conv_pkg::word_out_t'($signed(prod[c][u][w]));
      end
      assign out_beat.data[c][u] = acc_q[c][u][`CONV_KW-1];  // Top tap holds the result
    end
  end

  assign out_beat.last = out_last_q;

  // Sum registers hold payload only
  always_ff @(posedge clk) begin
    if (take) begin
      for (int c = 0; c < `CONV_CORES; c++) begin
        for (int u = 0; u < `CONV_UNITS; u++) begin
          for (int w = 0; w < `CONV_KW; w++) begin
            acc_q[c][u][w] <= sum_d[c][u][w];
          end
          if (tag.cin_last) begin
            for (int w = 0; w < `CONV_KW-1; w++) begin
              carry_q[c][u][w] <= sum_d[c][u][w];  // Hand column sum up the chain
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_first_q <= 1'b1;
      out_valid   <= 1'b0;
      out_last_q  <= 1'b0;
    end else if (en) begin
      out_valid  <= tag_valid && tag.cin_last && tag.emit;  // Warm-up columns dropped
      out_last_q <= tag_valid && tag.last;
      if (tag_valid) begin
        col_first_q <= tag.cin_last;
      end
    end
  end

endmodule

`default_nettype wire

// File: out_stage.sv
// Output register and stall enable
`timescale 1ns/1ps
`default_nettype none

module out_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  conv_pkg::conv_out_t in_beat,   // Candidate from tap chain
  input  logic                in_valid,
  input  logic                m_ready,
  output logic                m_valid,
  output conv_pkg::conv_out_t m_beat,
  output logic                en         // Whole pipeline advance
);

  // Free slot or slot draining now
  assign en = !m_valid || m_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (en) begin
      m_valid <= in_valid;               // Drops when drained without refill
    end
  end

  // Payload held while stalled
  always_ff @(posedge clk) begin
    if (en && in_valid) begin
      m_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

// File: conv_engine.sv
// Streaming 1-D convolution engine
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                s_valid,
  input  conv_pkg::conv_in_t  s_beat,
  output logic                s_ready,
  output logic                m_valid,
  output conv_pkg::conv_out_t m_beat,
  input  logic                m_ready
);

  logic                en;           // Freeze for back-pressure
  conv_pkg::prod_t     prod;
  conv_pkg::beat_tag_t tag;
  logic                tag_valid;
  conv_pkg::conv_out_t cand_beat;    // Finished sums before the output register
  logic                cand_valid;

  assign s_ready = en;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath and control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mul_pipe u_mul (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .in_valid   (s_valid),
    .in_beat    (s_beat),
    .prod       (prod),
    .prod_valid ()
  );

  conv_control u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .in_valid   (s_valid),
    .cin_last   (s_beat.cin_last),
    .last       (s_beat.last),
    .tag        (tag),
    .tag_valid  (tag_valid)
  );

  tap_chain u_taps (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .prod       (prod),
    .tag        (tag),
    .tag_valid  (tag_valid),
    .out_beat   (cand_beat),
    .out_valid  (cand_valid)
  );

  out_stage u_out (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_beat    (cand_beat),
    .in_valid   (cand_valid),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_beat     (m_beat),
    .en         (en)
  );

endmodule

`default_nettype wire

// File: conv_engine_props.sv
// Stream protocol properties
`timescale 1ns/1ps
`default_nettype none
`include "conv_defines.svh"

module conv_engine_props (
  input logic                clk,
  input logic                rst_n,
  input logic                s_valid,
  input conv_pkg::conv_in_t  s_beat,
  input logic                s_ready,
  input logic                m_valid,
  input conv_pkg::conv_out_t m_beat,
  input logic                m_ready
);

  logic                      take;       // Input transfer
  logic                      emit_end;   // Transfer closes an output column
  logic [`CONV_COL_BITS-1:0] col_q;      // Column index seen on the stream

  assign take     = s_valid && s_ready;
  assign emit_end = take && s_beat.cin_last && (col_q >= `CONV_COL_BITS'(`CONV_KW-1));

  // Column position from the stream alone
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (take && s_beat.last) begin
      col_q <= '0;                       // Row closed
    end else if (take && s_beat.cin_last) begin
      col_q <= col_q + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_reset_idle: assert property (@(posedge clk) !rst_n |=> (!m_valid && s_ready))
    else $error("Output valid or input stalled right after reset");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else $error("Output beat changed while the sink stalled");

  // Ready held high across the whole window
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(emit_end && m_ready, 4) && $past(m_ready, 3) &&
       $past(m_ready, 2) && $past(m_ready, 1)) |-> m_valid)
    else $error("Output valid missing four cycles after a closing column");

endmodule

bind conv_engine conv_engine_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_valid (s_valid),
  .s_beat  (s_beat),
  .s_ready (s_ready),
  .m_valid (m_valid),
  .m_beat  (m_beat),
  .m_ready (m_ready)
);

`default_nettype wire

// File: tb_conv_engine.sv
// Convolution engine testbench
`timescale 1ns/1ps
`default_nettype none
`include "conv_defines.svh"

module tb_conv_engine;

  localparam int KW          = `CONV_KW;
  localparam int MAX_COLS    = 8;
  localparam int MAX_CH      = 4;
  localparam int TOTAL_BEATS = 3 + 24 + 4 + 2*5*2 + 2*7*3;   // Beats over all tests
  localparam int LIMIT_NS    = (TOTAL_BEATS*4 + 200) * 20;

  logic                clk;
  logic                rst_n;
  logic                s_valid;
  conv_pkg::conv_in_t  s_beat;
  logic                s_ready;
  logic                m_valid;
  conv_pkg::conv_out_t m_beat;
  logic                m_ready;

  logic [31:0]         lfsr;             // Shared random stream
  logic                ready_random;     // Sink throttling on
  logic                gaps_on;          // Source gaps on
  logic                emit_drv;         // Offered beat closes an output column
  logic                idle_chk;         // Output must stay quiet
  int                  errors;
  int                  err_mark;         // Errors before current test
  int                  test_num;
  int                  tests_failed;
  conv_pkg::conv_out_t exp_q [$];        // Expected outputs in order
  conv_pkg::conv_out_t exp_head;         // Copy of queue head for the checks
  logic                exp_any;

  conv_pkg::word_in_t  px [MAX_COLS][MAX_CH][`CONV_UNITS];  // Row pixels
  conv_pkg::word_in_t  wt [`CONV_CORES][KW][MAX_CH];        // Row kernel

  conv_engine UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_beat  (s_beat),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_beat  (m_beat),
    .m_ready (m_ready)
  );

  always #10 clk = ~clk;                 // 20 ns period

  initial begin
    #(LIMIT_NS);
    $display("timeout: expected outputs still missing after %0d ns", LIMIT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_data: assert property (@(posedge clk) disable iff (!rst_n)
      (m_valid && m_ready && exp_any) |-> (m_beat == exp_head))
    else begin
      errors++;
      $display("error: m_beat = %h, expected %h", $sampled(m_beat), $sampled(exp_head));
    end

  a_extra: assert property (@(posedge clk) disable iff (!rst_n)
      (m_valid && m_ready) |-> exp_any)
    else begin
      errors++;
      $display("output beat delivered when none was expected");
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else begin
      errors++;
      $display("output beat changed or vanished while the sink stalled");
    end

  a_reset: assert property (@(posedge clk) !rst_n |=> (!m_valid && s_ready))
    else begin
      errors++;
      $display("error: m_valid = %h, s_ready = %h right after reset", $sampled(m_valid),
               $sampled(s_ready));
    end

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
      idle_chk |-> (!m_valid && s_ready))
    else begin
      errors++;
      $display("error: m_valid = %h, s_ready = %h with no input", $sampled(m_valid),
               $sampled(s_ready));
    end

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(s_valid && s_ready && emit_drv && m_ready, 4) && $past(m_ready, 3) &&
       $past(m_ready, 2) && $past(m_ready, 1)) |-> m_valid)
    else begin
      errors++;
      $display("error: m_valid = %h four cycles after a closing column", $sampled(m_valid));
    end

  // Queue head advances on every output transfer
  always @(posedge clk) begin
    if (rst_n && m_valid && m_ready && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      exp_any = (exp_q.size() != 0);
      if (exp_any) begin
        exp_head = exp_q[0];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois, right shift
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);            // One step per bit
    end
    return v;
  endfunction

  task automatic tick();
    @(negedge clk);
    if (ready_random) begin
      m_ready = (take_bits(2) != 32'd0); // Ready three cycles in four
    end
  endtask

  task automatic send_beat(input conv_pkg::conv_in_t b, input logic emit);
    logic took;
    if (gaps_on) begin
      while (take_bits(2) == 32'd0) begin
        tick();                          // Source idles this cycle
      end
    end
    s_valid  = 1'b1;
    s_beat   = b;
    emit_drv = emit;
    do begin
      @(posedge clk);
      took = s_ready;                    // Value at the edge itself
      tick();
    end while (!took);
    s_valid  = 1'b0;
    emit_drv = 1'b0;
  endtask

  task automatic make_row(input int ncols, input int nch);
    for (int j = 0; j < ncols; j++) begin
      for (int ch = 0; ch < nch; ch++) begin
        for (int u = 0; u < `CONV_UNITS; u++) begin
          px[j][ch][u] = conv_pkg::word_in_t'(take_bits(8));
        end
      end
    end
    for (int c = 0; c < `CONV_CORES; c++) begin
      for (int w = 0; w < KW; w++) begin
        for (int ch = 0; ch < nch; ch++) begin
          wt[c][w][ch] = conv_pkg::word_in_t'(take_bits(8));
        end
      end
    end
  endtask

  // Y(j) sums px(j-KW+1+w, ch) * wt(w, ch) for j from KW-1 on
  task automatic expect_row(input int ncols, input int nch);
    conv_pkg::conv_out_t e;
    int                  sum;
    for (int j = KW-1; j < ncols; j++) begin
      for (int c = 0; c < `CONV_CORES; c++) begin
        for (int u = 0; u < `CONV_UNITS; u++) begin
          sum = 0;
          for (int w = 0; w < KW; w++) begin
            for (int ch = 0; ch < nch; ch++) begin
              sum += int'(px[j-KW+1+w][ch][u]) * int'(wt[c][w][ch]);
            end
          end
          e.data[c][u] = conv_pkg::word_out_t'(sum);
        end
      end
      e.last = (j == ncols-1);           // Only the row's final output
      exp_q.push_back(e);
    end
    if (exp_q.size() != 0) begin
      exp_head = exp_q[0];
      exp_any  = 1'b1;
    end
  endtask

  task automatic run_row(input int ncols, input int nch);
    conv_pkg::conv_in_t b;
    make_row(ncols, nch);
    expect_row(ncols, nch);
    for (int j = 0; j < ncols; j++) begin
      for (int ch = 0; ch < nch; ch++) begin
        for (int u = 0; u < `CONV_UNITS; u++) begin
          b.pixels[u] = px[j][ch][u];
        end
        for (int c = 0; c < `CONV_CORES; c++) begin
          for (int w = 0; w < KW; w++) begin
            b.weights[c][w] = wt[c][w][ch];
          end
        end
        b.cin_last = (ch == nch-1);
        b.last     = b.cin_last && (j == ncols-1);
        send_beat(b, b.cin_last && (j >= KW-1));
      end
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      tick();
    end
    repeat (8) tick();                   // Window for any stray beat
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    s_valid      = 1'b0;
    s_beat       = '0;
    m_ready      = 1'b1;
    lfsr         = 32'h4b62_43e5;
    ready_random = 1'b0;
    gaps_on      = 1'b0;
    emit_drv     = 1'b0;
    idle_chk     = 1'b0;
    errors       = 0;
    err_mark     = 0;
    test_num     = 0;
    tests_failed = 0;
    exp_head     = '0;
    exp_any      = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    idle_chk = 1'b1;
    repeat (10) tick();
    idle_chk = 1'b0;
    end_test("reset idle");

    run_row(KW, 1);
    drain();
    end_test("single window");

    run_row(6, 4);
    drain();
    end_test("six columns four channels");

    run_row(2, 2);                       // Shorter than the kernel
    drain();
    end_test("short row");

    run_row(5, 2);
    run_row(5, 2);
    drain();
    end_test("two rows");

    ready_random = 1'b1;
    gaps_on      = 1'b1;
    run_row(7, 3);
    run_row(7, 3);
    drain();
    ready_random = 1'b0;
    m_ready      = 1'b1;
    end_test("random stalls");

    $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: conv_engine.f
+incdir+.
conv_pkg.sv
mul_pipe.sv
conv_control.sv
tap_chain.sv
out_stage.sv
conv_engine.sv
conv_engine_props.sv
tb_conv_engine.sv

// File: Makefile
# Verilator flow for the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_engine
FILELIST  ?= conv_engine.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
